//--- hw/la_pkg.sv
`default_nettype none

package la_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    // operation selector carried from decode to exec
    typedef logic [3:0] alu_op_e;

    localparam alu_op_e OP_ADD   = 4'd0;
    localparam alu_op_e OP_SUB   = 4'd1;
    localparam alu_op_e OP_AND   = 4'd2;
    localparam alu_op_e OP_OR    = 4'd3;
    localparam alu_op_e OP_XOR   = 4'd4;
    localparam alu_op_e OP_SLT   = 4'd5;
    localparam alu_op_e OP_LUI   = 4'd6;
    localparam alu_op_e OP_LOAD  = 4'd7;
    localparam alu_op_e OP_STORE = 4'd8;
    localparam alu_op_e OP_BEQ   = 4'd9;
    localparam alu_op_e OP_BNE   = 4'd10;
    localparam alu_op_e OP_B     = 4'd11;
    localparam alu_op_e OP_NOP   = 4'd12;

    typedef struct packed {
        alu_op_e   op;
        reg_addr_t rj;
        reg_addr_t rk;
        reg_addr_t rd;
        logic      we;
        word_t     imm;
    } decoded_inst_t;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    // 3R format, inst[31:15]
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_SLT   = 17'h00024;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002a;
    localparam logic [16:0] OPC_XOR   = 17'h0002b;

    // 2RI12 format, inst[31:22]
    localparam logic [9:0] OPC_ADDI_W = 10'h00a;
    localparam logic [9:0] OPC_LD_W   = 10'h0a2;
    localparam logic [9:0] OPC_ST_W   = 10'h0a6;

    // 1RI20 format, inst[31:25]
    localparam logic [6:0] OPC_LU12I_W = 7'h0a;

    // branches, inst[31:26]
    localparam logic [5:0] OPC_B   = 6'h14;
    localparam logic [5:0] OPC_BEQ = 6'h16;
    localparam logic [5:0] OPC_BNE = 6'h17;

endpackage

`default_nettype wire

//--- hw/la_fetch.sv
`default_nettype none
`timescale 1ns/100ps

module la_fetch #(
    parameter la_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  wire                clk_i,
    input  wire                rst_n_i,
    output logic               fetch_valid_o,
    output la_pkg::word_t      fetch_addr_o,
    input  wire                fetch_ready_i,
    input  wire la_pkg::inst_t fetch_data_i,
    output logic               inst_valid_o,
    output la_pkg::inst_t      inst_o,
    output la_pkg::word_t      inst_pc_o,
    input  wire                inst_take_i,
    input  wire                redirect_valid_i,
    input  wire la_pkg::word_t redirect_pc_i
);
    import la_pkg::*;

    word_t pc_q;
    word_t req_addr_q;
    logic  req_q;
    logic  stale_q;
    logic  buf_valid_q;
    inst_t buf_inst_q;
    word_t buf_pc_q;
    logic  issue;
    logic  fill;

    // next fetch leaves as soon as the buffer is empty or being drained
    assign issue = !req_q && (!buf_valid_q || inst_take_i);
    assign fill  = req_q && fetch_ready_i && !stale_q && !redirect_valid_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q        <= RESET_PC;
            req_q       <= 1'b0;
            stale_q     <= 1'b0;
            buf_valid_q <= 1'b0;
        end else begin
            if (req_q && fetch_ready_i) begin
                req_q   <= 1'b0;
                stale_q <= 1'b0;
            end else if (issue) begin
                req_q <= 1'b1;
            end
            // wrong-path fetch still has to finish at the port
            if (redirect_valid_i && (issue || (req_q && !fetch_ready_i))) begin
                stale_q <= 1'b1;
            end
            if (redirect_valid_i) begin
                pc_q <= redirect_pc_i;
            end else if (issue) begin
                pc_q <= pc_q + 32'd4;
            end
            if (fill) begin
                buf_valid_q <= 1'b1;
            end else if (inst_take_i || redirect_valid_i) begin
                buf_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            req_addr_q <= pc_q;
        end
        if (fill) begin
            buf_inst_q <= fetch_data_i;
            buf_pc_q   <= req_addr_q;
        end
    end

    assign fetch_valid_o = req_q;
    assign fetch_addr_o  = req_addr_q;
    assign inst_valid_o  = buf_valid_q;
    assign inst_o        = buf_inst_q;
    assign inst_pc_o     = buf_pc_q;

    fetch_addr_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fetch_valid_o && !fetch_ready_i |=> fetch_valid_o && $stable(fetch_addr_o));

endmodule

`default_nettype wire

//--- hw/la_decode.sv
`default_nettype none
`timescale 1ns/100ps

module la_decode (
    input  wire la_pkg::inst_t    inst_i,
    output la_pkg::decoded_inst_t dec_o
);
    import la_pkg::*;

    word_t si12;
    word_t si20;
    word_t offs16;
    word_t offs26;

    assign si12   = {{20{inst_i[21]}}, inst_i[21:10]};
    assign si20   = {inst_i[24:5], 12'b0};
    assign offs16 = {{14{inst_i[25]}}, inst_i[25:10], 2'b0};
    assign offs26 = {{4{inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b0};

    always_comb begin
        dec_o    = '0;
        dec_o.op = OP_NOP;
        dec_o.rj = inst_i[9:5];
        dec_o.rk = inst_i[14:10];
        dec_o.rd = inst_i[4:0];

        if (inst_i[31:22] == OPC_ADDI_W) begin
            // add with rk forced to r0, exec sums rj + rk + imm
            dec_o.op  = OP_ADD;
            dec_o.rk  = '0;
            dec_o.we  = 1'b1;
            dec_o.imm = si12;
        end else if (inst_i[31:22] == OPC_LD_W) begin
            dec_o.op  = OP_LOAD;
            dec_o.we  = 1'b1;
            dec_o.imm = si12;
        end else if (inst_i[31:22] == OPC_ST_W) begin
            // store data comes from rd
            dec_o.op  = OP_STORE;
            dec_o.rk  = inst_i[4:0];
            dec_o.imm = si12;
        end else if (inst_i[31:25] == OPC_LU12I_W) begin
            dec_o.op  = OP_LUI;
            dec_o.we  = 1'b1;
            dec_o.imm = si20;
        end else if (inst_i[31:26] == OPC_BEQ || inst_i[31:26] == OPC_BNE) begin
            dec_o.op  = (inst_i[26]) ? OP_BNE : OP_BEQ;
            dec_o.rk  = inst_i[4:0];
            dec_o.imm = offs16;
        end else if (inst_i[31:26] == OPC_B) begin
            dec_o.op  = OP_B;
            dec_o.imm = offs26;
        end else begin
            case (inst_i[31:15])
                OPC_ADD_W: dec_o.op = OP_ADD;
                OPC_SUB_W: dec_o.op = OP_SUB;
                OPC_SLT:   dec_o.op = OP_SLT;
                OPC_AND:   dec_o.op = OP_AND;
                OPC_OR:    dec_o.op = OP_OR;
                OPC_XOR:   dec_o.op = OP_XOR;
                default:   dec_o.op = OP_NOP;
            endcase
            dec_o.we = (dec_o.op != OP_NOP);
        end
    end

endmodule

`default_nettype wire

//--- hw/la_regfile.sv
`default_nettype none
`timescale 1ns/100ps

module la_regfile (
    input  wire                    clk_i,
    input  wire                    rst_n_i,
    input  wire la_pkg::reg_addr_t rd_addr_a_i,
    input  wire la_pkg::reg_addr_t rd_addr_b_i,
    output la_pkg::word_t          rd_data_a_o,
    output la_pkg::word_t          rd_data_b_o,
    input  wire                    wr_en_i,
    input  wire la_pkg::reg_addr_t wr_addr_i,
    input  wire la_pkg::word_t     wr_data_i
);
    import la_pkg::*;

    word_t regs_q [32];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // r0 reads as zero
    assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 : regs_q[rd_addr_a_i];
    assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 : regs_q[rd_addr_b_i];

endmodule

`default_nettype wire

//--- hw/la_exec.sv
`default_nettype none
`timescale 1ns/100ps

module la_exec (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire                        inst_valid_i,
    input  wire la_pkg::decoded_inst_t dec_i,
    input  wire la_pkg::word_t         inst_pc_i,
    output logic                       inst_take_o,
    output la_pkg::reg_addr_t          rd_addr_a_o,
    output la_pkg::reg_addr_t          rd_addr_b_o,
    input  wire la_pkg::word_t         rd_data_a_i,
    input  wire la_pkg::word_t         rd_data_b_i,
    output logic                       wr_en_o,
    output la_pkg::reg_addr_t          wr_addr_o,
    output la_pkg::word_t              wr_data_o,
    output logic                       redirect_valid_o,
    output la_pkg::word_t              redirect_pc_o,
    output logic                       lsu_start_o,
    output la_pkg::mem_req_t           lsu_req_o,
    input  wire                        lsu_done_i,
    input  wire la_pkg::word_t         lsu_data_i
);
    import la_pkg::*;

    logic  started_q;
    logic  is_mem;
    logic  taken;
    word_t alu_res;

    assign rd_addr_a_o = dec_i.rj;
    assign rd_addr_b_o = dec_i.rk;

    assign is_mem = (dec_i.op == OP_LOAD) || (dec_i.op == OP_STORE);

    always_comb begin
        case (dec_i.op)
            // imm is zero for add.w, rk is r0 for addi.w
            OP_ADD:  alu_res = rd_data_a_i + rd_data_b_i + dec_i.imm;
            OP_SUB:  alu_res = rd_data_a_i - rd_data_b_i;
            OP_AND:  alu_res = rd_data_a_i & rd_data_b_i;
            OP_OR:   alu_res = rd_data_a_i | rd_data_b_i;
            OP_XOR:  alu_res = rd_data_a_i ^ rd_data_b_i;
            OP_SLT:  alu_res = {31'b0, $signed(rd_data_a_i) < $signed(rd_data_b_i)};
            OP_LUI:  alu_res = dec_i.imm;
            OP_LOAD: alu_res = lsu_data_i;
            default: alu_res = '0;
        endcase
    end

    always_comb begin
        case (dec_i.op)
            OP_B:    taken = 1'b1;
            OP_BEQ:  taken = (rd_data_a_i == rd_data_b_i);
            OP_BNE:  taken = (rd_data_a_i != rd_data_b_i);
            default: taken = 1'b0;
        endcase
    end

    assign redirect_valid_o = inst_valid_i && taken;
    assign redirect_pc_o    = inst_pc_i + dec_i.imm;

    // one lsu request per memory instruction
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            started_q <= 1'b0;
        end else if (lsu_done_i) begin
            started_q <= 1'b0;
        end else if (lsu_start_o) begin
            started_q <= 1'b1;
        end
    end

    assign lsu_start_o = inst_valid_i && is_mem && !started_q;
    assign lsu_req_o   = '{we: (dec_i.op == OP_STORE),
                           addr: rd_data_a_i + dec_i.imm,
                           wdata: rd_data_b_i};

    assign inst_take_o = inst_valid_i && (!is_mem || (started_q && lsu_done_i));
    assign wr_en_o     = inst_take_o && dec_i.we;
    assign wr_addr_o   = dec_i.rd;
    assign wr_data_o   = alu_res;

endmodule

`default_nettype wire

//--- hw/la_lsu.sv
`default_nettype none
`timescale 1ns/100ps

module la_lsu (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  wire                   lsu_start_i,
    input  wire la_pkg::mem_req_t lsu_req_i,
    output logic                  lsu_done_o,
    output la_pkg::word_t         lsu_data_o,
    output logic                  lsu_valid_o,
    output la_pkg::mem_req_t      lsu_mem_o,
    input  wire                   lsu_ready_i,
    input  wire la_pkg::word_t    lsu_rdata_i
);
    import la_pkg::*;

    typedef enum logic {
        LSU_IDLE,
        LSU_BUSY
    } lsu_state_e;

    lsu_state_e state_q;
    mem_req_t   req_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= LSU_IDLE;
        end else if (state_q == LSU_IDLE && lsu_start_i) begin
            state_q <= LSU_BUSY;
        end else if (state_q == LSU_BUSY && lsu_ready_i) begin
            state_q <= LSU_IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == LSU_IDLE && lsu_start_i) begin
            req_q <= lsu_req_i;
        end
    end

    assign lsu_valid_o = (state_q == LSU_BUSY);
    assign lsu_mem_o   = req_q;
    assign lsu_done_o  = (state_q == LSU_BUSY) && lsu_ready_i;
    assign lsu_data_o  = lsu_rdata_i;

    // exec must wait for done before the next start
    no_start_busy_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(lsu_start_i && state_q == LSU_BUSY));

endmodule

`default_nettype wire

//--- hw/la_mem_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module la_mem_arbiter (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  wire                   fetch_valid_i,
    input  wire la_pkg::word_t    fetch_addr_i,
    output logic                  fetch_ready_o,
    output la_pkg::inst_t         fetch_data_o,
    input  wire                   lsu_valid_i,
    input  wire la_pkg::mem_req_t lsu_mem_i,
    output logic                  lsu_ready_o,
    output la_pkg::word_t         lsu_rdata_o,
    output logic                  mem_valid_o,
    output la_pkg::mem_req_t      mem_req_o,
    input  wire                   mem_ready_i,
    input  wire la_pkg::word_t    mem_rdata_i
);
    import la_pkg::*;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_FETCH,
        ARB_DATA
    } arb_state_e;

    arb_state_e state_q;
    mem_req_t   req_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ARB_IDLE;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    // data side first
                    if (lsu_valid_i) begin
                        state_q <= ARB_DATA;
                    end else if (fetch_valid_i) begin
                        state_q <= ARB_FETCH;
                    end
                end
                default: begin
                    if (mem_ready_i) begin
                        state_q <= ARB_IDLE;
                    end
                end
            endcase
        end
    end

    // port request only moves while idle
    always_ff @(posedge clk_i) begin
        if (state_q == ARB_IDLE) begin
            if (lsu_valid_i) begin
                req_q <= lsu_mem_i;
            end else begin
                req_q <= '{we: 1'b0, addr: fetch_addr_i, wdata: '0};
            end
        end
    end

    assign mem_valid_o   = (state_q != ARB_IDLE);
    assign mem_req_o     = req_q;
    assign fetch_ready_o = (state_q == ARB_FETCH) && mem_ready_i;
    assign lsu_ready_o   = (state_q == ARB_DATA) && mem_ready_i;
    assign fetch_data_o  = mem_rdata_i;
    assign lsu_rdata_o   = mem_rdata_i;

    // each completion goes to exactly one requester that is still asking
    one_grant_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_valid_o && mem_ready_i
            |-> $onehot({fetch_ready_o && fetch_valid_i, lsu_ready_o && lsu_valid_i}));

    req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_req_o));

endmodule

`default_nettype wire

//--- hw/la_cpu.sv
`default_nettype none
`timescale 1ns/100ps

module la_cpu #(
    parameter la_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  wire                clk_i,
    input  wire                rst_n_i,
    output logic               mem_valid_o,
    output la_pkg::mem_req_t   mem_req_o,
    input  wire                mem_ready_i,
    input  wire la_pkg::word_t mem_rdata_i
);
    import la_pkg::*;

    // fetch and arbiter
    logic  fetch_valid;
    word_t fetch_addr;
    logic  fetch_ready;
    inst_t fetch_data;

    // fetch, decode and exec
    logic          inst_valid;
    inst_t         inst;
    word_t         inst_pc;
    logic          inst_take;
    logic          redirect_valid;
    word_t         redirect_pc;
    decoded_inst_t dec;

    // exec and regfile
    reg_addr_t rd_addr_a;
    reg_addr_t rd_addr_b;
    word_t     rd_data_a;
    word_t     rd_data_b;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    // exec, lsu and arbiter
    logic     lsu_start;
    mem_req_t lsu_req;
    logic     lsu_done;
    word_t    lsu_data;
    logic     lsu_valid;
    mem_req_t lsu_mem;
    logic     lsu_ready;
    word_t    lsu_rdata;

    la_fetch #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .fetch_valid_o   (fetch_valid),
        .fetch_addr_o    (fetch_addr),
        .fetch_ready_i   (fetch_ready),
        .fetch_data_i    (fetch_data),
        .inst_valid_o    (inst_valid),
        .inst_o          (inst),
        .inst_pc_o       (inst_pc),
        .inst_take_i     (inst_take),
        .redirect_valid_i(redirect_valid),
        .redirect_pc_i   (redirect_pc)
    );

    la_decode u_decode (
        .inst_i(inst),
        .dec_o (dec)
    );

    la_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rd_addr_a_i(rd_addr_a),
        .rd_addr_b_i(rd_addr_b),
        .rd_data_a_o(rd_data_a),
        .rd_data_b_o(rd_data_b),
        .wr_en_i    (wr_en),
        .wr_addr_i  (wr_addr),
        .wr_data_i  (wr_data)
    );

    la_exec u_exec (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .inst_valid_i    (inst_valid),
        .dec_i           (dec),
        .inst_pc_i       (inst_pc),
        .inst_take_o     (inst_take),
        .rd_addr_a_o     (rd_addr_a),
        .rd_addr_b_o     (rd_addr_b),
        .rd_data_a_i     (rd_data_a),
        .rd_data_b_i     (rd_data_b),
        .wr_en_o         (wr_en),
        .wr_addr_o       (wr_addr),
        .wr_data_o       (wr_data),
        .redirect_valid_o(redirect_valid),
        .redirect_pc_o   (redirect_pc),
        .lsu_start_o     (lsu_start),
        .lsu_req_o       (lsu_req),
        .lsu_done_i      (lsu_done),
        .lsu_data_i      (lsu_data)
    );

    la_lsu u_lsu (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .lsu_start_i(lsu_start),
        .lsu_req_i  (lsu_req),
        .lsu_done_o (lsu_done),
        .lsu_data_o (lsu_data),
        .lsu_valid_o(lsu_valid),
        .lsu_mem_o  (lsu_mem),
        .lsu_ready_i(lsu_ready),
        .lsu_rdata_i(lsu_rdata)
    );

    la_mem_arbiter u_mem_arbiter (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .fetch_valid_i(fetch_valid),
        .fetch_addr_i (fetch_addr),
        .fetch_ready_o(fetch_ready),
        .fetch_data_o (fetch_data),
        .lsu_valid_i  (lsu_valid),
        .lsu_mem_i    (lsu_mem),
        .lsu_ready_o  (lsu_ready),
        .lsu_rdata_o  (lsu_rdata),
        .mem_valid_o  (mem_valid_o),
        .mem_req_o    (mem_req_o),
        .mem_ready_i  (mem_ready_i),
        .mem_rdata_i  (mem_rdata_i)
    );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clock #(
    parameter int HALF_PERIOD_NS = 10
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD_NS clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

//--- test/tb_la_cpu.sv
`default_nettype none
`timescale 1ns/100ps

module tb_la_cpu;
    import la_pkg::*;

    localparam word_t RESET_PC     = 32'h0000_0000;
    localparam int    RESET_CYCLES = 10;
    localparam int    IN_DELAY     = 2;
    localparam int    MEM_WORDS    = 256;
    localparam int    FIRST_TIMEOUT = 20;
    localparam int    RUN_TIMEOUT  = 5000;
    localparam int    DRAIN_CYCLES = 50;
    localparam word_t FILL         = 32'hbad0_0000;
    localparam string GOLDEN_FILE  = "test/golden_program.txt";

    logic     clk;
    logic     rst_n;
    logic     mem_valid;
    mem_req_t mem_req;
    logic     mem_ready;
    word_t    mem_rdata;

    word_t    mem [MEM_WORDS];
    word_t    exp_addr [$];
    word_t    exp_data [$];
    logic     busy;
    int       wait_left;
    mem_req_t held_req;
    int       cycles;

    tb_clock #(
        .HALF_PERIOD_NS(10)
    ) i_clock (
        .clk_o(clk)
    );

    la_cpu #(
        .RESET_PC(RESET_PC)
    ) i_dut (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .mem_valid_o(mem_valid),
        .mem_req_o  (mem_req),
        .mem_ready_i(mem_ready),
        .mem_rdata_i(mem_rdata)
    );

    task automatic abort_run(input string why);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic compare_word(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s is %08h, expected %08h",
                     $time, what, actual, expected);
            abort_run("value mismatch");
        end
    endtask

    // wdata is only meaningful when the caller asks for it
    task automatic compare_req(input mem_req_t actual, input mem_req_t expected,
                               input logic check_wdata, input string what);
        if (actual.we !== expected.we || actual.addr !== expected.addr ||
            (check_wdata && actual.wdata !== expected.wdata)) begin
            $display("MISMATCH at %0t: %s is we=%0b addr=%08h wdata=%08h",
                     $time, what, actual.we, actual.addr, actual.wdata);
            $display("    expected we=%0b addr=%08h wdata=%08h",
                     expected.we, expected.addr, expected.wdata);
            abort_run("value mismatch");
        end
    endtask

    task automatic load_golden();
        int    fd;
        int    fields;
        string line;
        byte   kind;
        word_t addr;
        word_t data;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = FILL | word_t'(i << 2);
        end
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the golden file");
        end
        while ($fgets(line, fd) != 0) begin
            kind = line.getc(0);
            if (kind == "P" || kind == "S") begin
                fields = $sscanf(line.substr(1, line.len() - 1), "%h %h", addr, data);
                if (fields != 2) begin
                    abort_run("malformed line in the golden file");
                end
                if (kind == "P") begin
                    mem[addr[9:2]] = data;
                end else begin
                    exp_addr.push_back(addr);
                    exp_data.push_back(data);
                end
            end
        end
        $fclose(fd);
        if (exp_addr.size() == 0) begin
            abort_run("golden file holds no expected stores");
        end
    endtask

    task automatic check_store(input mem_req_t req);
        mem_req_t expected;
        if (exp_addr.size() == 0) begin
            abort_run("store seen after the last expected store");
        end
        expected = '{we: 1'b1, addr: exp_addr[0], wdata: exp_data[0]};
        compare_req(req, expected, 1'b0, "store request");
        compare_word(req.wdata, exp_data[0], "store data");
        exp_addr.delete(0);
        exp_data.delete(0);
    endtask

    task automatic complete_transfer();
        if (held_req.addr[1:0] != 2'b00) begin
            abort_run("unaligned memory access");
        end
        if (held_req.we) begin
            check_store(held_req);
            mem[held_req.addr[9:2]] = held_req.wdata;
            mem_rdata = '0;
        end else begin
            mem_rdata = mem[held_req.addr[9:2]];
        end
        mem_ready = 1'b1;
    endtask

    // one memory cycle, called just after each rising edge
    task automatic serve_memory();
        if (mem_ready) begin
            mem_ready = 1'b0;
            busy      = 1'b0;
        end else if (busy) begin
            if (mem_valid !== 1'b1) begin
                abort_run("request withdrawn before mem_ready_i");
            end
            compare_req(mem_req, held_req, 1'b1, "waiting request");
        end else if (mem_valid === 1'b1) begin
            busy      = 1'b1;
            held_req  = mem_req;
            wait_left = int'($urandom % 32'd4);
        end
        if (busy) begin
            if (wait_left == 0) begin
                complete_transfer();
            end else begin
                wait_left--;
            end
        end
    endtask

    initial begin
        void'($urandom(32'h6001e8fa));
        rst_n     = 1'b0;
        mem_ready = 1'b0;
        mem_rdata = '0;
        busy      = 1'b0;
        wait_left = 0;
        held_req  = '0;
        load_golden();

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            #IN_DELAY;
            if (mem_valid !== 1'b0) begin
                abort_run("memory request raised during reset");
            end
        end
        rst_n = 1'b1;

        // first port request has to be the fetch of the reset pc
        cycles = 0;
        do begin
            @(posedge clk);
            #IN_DELAY;
            cycles++;
            if (cycles > FIRST_TIMEOUT) begin
                abort_run("timeout waiting for the first request after reset");
            end
        end while (mem_valid !== 1'b1);
        compare_req(mem_req, '{we: 1'b0, addr: RESET_PC, wdata: '0}, 1'b0, "first request");
        serve_memory();

        cycles = 0;
        while (exp_addr.size() != 0) begin
            @(posedge clk);
            #IN_DELAY;
            serve_memory();
            cycles++;
            if (cycles > RUN_TIMEOUT) begin
                abort_run("timeout waiting for the expected stores");
            end
        end

        // a repeated store would still show up here
        for (int i = 0; i < DRAIN_CYCLES; i++) begin
            @(posedge clk);
            #IN_DELAY;
            serve_memory();
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/golden_program.txt
# P <byte address> <instruction word>   program image
# S <byte address> <store data>         expected stores, in order
P 00000000 02880001
P 00000004 02848c02
P 00000008 02bfe803
P 0000000c 00100c44
P 00000010 00110c45
P 00000014 00148c46
P 00000018 00150c47
P 0000001c 00158c48
P 00000020 00120869
P 00000024 00120c4a
P 00000028 142468ab
P 0000002c 0299e16c
P 00000030 29800024
P 00000034 29801025
P 00000038 29802026
P 0000003c 29803027
P 00000040 29804028
P 00000044 29805029
P 00000048 2980602a
P 0000004c 2980702c
# store, load back, store plus one
P 00000050 29808022
P 00000054 2880802d
P 00000058 028005ad
P 0000005c 2980902d
# write to r0, then store r0
P 00000060 02815400
P 00000064 2980a020
# branches, taken ones skip the next store
P 00000068 58000842
P 0000006c 2980b022
P 00000070 5c000843
P 00000074 2980c023
P 00000078 58000843
P 0000007c 2980d029
P 00000080 5c000842
P 00000084 2980e025
P 00000088 50000800
P 0000008c 2980f026
P 00000090 2981002b
# backward loop, three passes
P 00000094 02800c0f
P 00000098 028005ce
P 0000009c 2981102e
P 000000a0 5ffff9cf
P 000000a4 50000000
S 00000200 0000011d
S 00000204 00000129
S 00000208 00000122
S 0000020c fffffffb
S 00000210 fffffed9
S 00000214 00000001
S 00000218 00000000
S 0000021c 12345678
S 00000220 00000123
S 00000224 00000124
S 00000228 00000000
S 00000234 00000001
S 00000238 00000129
S 00000240 12345000
S 00000244 00000001
S 00000244 00000002
S 00000244 00000003

//--- tb.f
hw/la_pkg.sv
hw/la_fetch.sv
hw/la_decode.sv
hw/la_regfile.sv
hw/la_exec.sv
hw/la_lsu.sv
hw/la_mem_arbiter.sv
hw/la_cpu.sv
test/tb_clock.sv
test/tb_la_cpu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_la_cpu -f tb.f -o sim_tb_la_cpu
./obj_dir/sim_tb_la_cpu
